/* src/imuldiv_defs.svh */
// --------------------------------------------------
// imuldiv parameters
// widths and iteration count of the mul/div unit
// --------------------------------------------------

`ifndef IMULDIV_DEFS_SVH
`define IMULDIV_DEFS_SVH

// operand width of the processor datapath
`define IMULDIV_XLEN 32

// one iteration per operand bit, no early exit
`define IMULDIV_STEPS 32

// step counter width
// must hold IMULDIV_STEPS - 1 with room to spare
`define IMULDIV_CNT_W 6

`endif

/* src/imuldiv_pkg.sv */
// --------------------------------------------------
// imuldiv types
// opcodes, control states and bundled signals
// --------------------------------------------------

`include "imuldiv_defs.svh"

package imuldiv_pkg;

  // --------------------------------------------------
  // enums
  // --------------------------------------------------

  // operation select carried with each request
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } imuldiv_op_e;

  // control FSM states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } imuldiv_state_e;

  // --------------------------------------------------
  // structs
  // --------------------------------------------------

  // request message, op on top then a then b
  typedef struct packed {
    imuldiv_op_e              op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } imuldiv_req_t;

  // control word broadcast to all datapath blocks
  typedef struct packed {
    // capture operands this cycle
    logic load;
    // one iteration this cycle
    logic step;
  } imuldiv_ctrl_t;

endpackage

/* src/imuldiv_ctrl.sv */
// --------------------------------------------------
// imuldiv control
// val/rdy handshakes, step counter, control word
// --------------------------------------------------

`timescale 1ns/1ns

`include "imuldiv_defs.svh"

module imuldiv_ctrl import imuldiv_pkg::*; (
  input  logic          clk,
  input  logic          reset,

  // request side
  input  logic          req_val,
  output logic          req_rdy,

  // response side
  output logic          resp_val,
  input  logic          resp_rdy,

  // to the datapath blocks
  output imuldiv_ctrl_t ctrl
);

  // last count value before leaving st_calc
  localparam logic [`IMULDIV_CNT_W-1:0] last_step = `IMULDIV_CNT_W'(`IMULDIV_STEPS - 1);

  imuldiv_state_e            state;
  logic [`IMULDIV_CNT_W-1:0] count;

  logic req_go;
  logic resp_go;

  // transfers on each side
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // state and counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          // operands are loaded at this same edge
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // exactly IMULDIV_STEPS cycles of step
          if (count == last_step) begin
            state <= st_done;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // everything holds until the response is taken
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
          count <= '0;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // outputs, decoded from state only
  // --------------------------------------------------

  always_comb begin
    req_rdy   = (state == st_idle);
    resp_val  = (state == st_done);
    // load only on an actual transfer
    ctrl.load = (state == st_idle) && req_val;
    // iterate for the whole calc phase
    ctrl.step = (state == st_calc);
  end

endmodule

/* src/imuldiv_sign_unit.sv */
// --------------------------------------------------
// imuldiv sign unit
// operand magnitudes in, signed result fix-up out
// --------------------------------------------------

`timescale 1ns/1ns

`include "imuldiv_defs.svh"

module imuldiv_sign_unit import imuldiv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,

  input  imuldiv_req_t               req,
  input  imuldiv_ctrl_t              ctrl,

  // unsigned results from the arithmetic blocks
  input  logic [2*`IMULDIV_XLEN-1:0] product_mag,
  input  logic [`IMULDIV_XLEN-1:0]   quot_mag,
  input  logic [`IMULDIV_XLEN-1:0]   rem_mag,

  // operand magnitudes to the arithmetic blocks
  output logic [`IMULDIV_XLEN-1:0]   mag_a,
  output logic [`IMULDIV_XLEN-1:0]   mag_b,

  output logic [2*`IMULDIV_XLEN-1:0] resp_result
);

  localparam int msb = `IMULDIV_XLEN - 1;

  // signs seen by the fix-up, forced low for unsigned divide
  logic neg_a;
  logic neg_b;

  // registered request info
  imuldiv_op_e op_q;
  logic        neg_a_q;
  logic        neg_b_q;
  logic        div_zero_q;

  // signed results
  logic [2*`IMULDIV_XLEN-1:0] product;
  logic [`IMULDIV_XLEN-1:0]   quot;
  logic [`IMULDIV_XLEN-1:0]   rem;

  // --------------------------------------------------
  // input side
  // --------------------------------------------------

  assign neg_a = (req.op != op_divu) && req.a[msb];
  assign neg_b = (req.op != op_divu) && req.b[msb];

  // two's complement magnitude, most negative value maps to 2^31
  assign mag_a = neg_a ? (~req.a + 1'b1) : req.a;
  assign mag_b = neg_b ? (~req.b + 1'b1) : req.b;

  always_ff @(posedge clk) begin
    if (reset) begin
      op_q       <= op_mul;
      neg_a_q    <= 1'b0;
      neg_b_q    <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (ctrl.load) begin
      op_q       <= req.op;
      neg_a_q    <= neg_a;
      neg_b_q    <= neg_b;
      div_zero_q <= (req.b == '0);
    end
  end

  // --------------------------------------------------
  // output side
  // --------------------------------------------------

  // product negative when exactly one operand is
  assign product = (neg_a_q ^ neg_b_q) ? (~product_mag + 1'b1) : product_mag;

  // quotient keeps all ones on a zero divisor
  assign quot = ((neg_a_q ^ neg_b_q) && !div_zero_q) ? (~quot_mag + 1'b1) : quot_mag;

  // remainder follows the dividend
  assign rem = neg_a_q ? (~rem_mag + 1'b1) : rem_mag;

  // divides return {remainder, quotient}
  assign resp_result = (op_q == op_mul) ? product : {rem, quot};

endmodule

/* src/imuldiv_mul_dpath.sv */
// --------------------------------------------------
// imuldiv multiplier datapath
// shift-add multiply of two operand magnitudes
// --------------------------------------------------

`timescale 1ns/1ns

`include "imuldiv_defs.svh"

module imuldiv_mul_dpath import imuldiv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,

  input  imuldiv_ctrl_t              ctrl,

  input  logic [`IMULDIV_XLEN-1:0]   mag_a,
  input  logic [`IMULDIV_XLEN-1:0]   mag_b,

  output logic [2*`IMULDIV_XLEN-1:0] product_mag
);

  // multiplicand widened so it can shift up into the top half
  logic [2*`IMULDIV_XLEN-1:0] mcand;
  logic [`IMULDIV_XLEN-1:0]   mplier;
  logic [2*`IMULDIV_XLEN-1:0] acc;

  // --------------------------------------------------
  // iteration
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      mcand  <= '0;
      mplier <= '0;
      acc    <= '0;
    end else if (ctrl.load) begin
      // zero-extend a, start with an empty sum
      mcand  <= {{`IMULDIV_XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (ctrl.step) begin
      // add the current partial product when this bit of b is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      // next bit of b lines up with a doubled multiplicand
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // after the last step the sum holds the full product
  assign product_mag = acc;

endmodule

/* src/imuldiv_div_dpath.sv */
// --------------------------------------------------
// imuldiv divider datapath
// restoring divide of two operand magnitudes
// --------------------------------------------------

`timescale 1ns/1ns

`include "imuldiv_defs.svh"

module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,

  input  imuldiv_ctrl_t            ctrl,

  // a is the dividend, b the divisor
  input  logic [`IMULDIV_XLEN-1:0] mag_a,
  input  logic [`IMULDIV_XLEN-1:0] mag_b,

  output logic [`IMULDIV_XLEN-1:0] quot_mag,
  output logic [`IMULDIV_XLEN-1:0] rem_mag
);

  localparam int msb = `IMULDIV_XLEN - 1;

  logic [`IMULDIV_XLEN-1:0] rem;
  logic [`IMULDIV_XLEN-1:0] quot;
  logic [`IMULDIV_XLEN-1:0] divisor;

  // remainder after the shift, one extra bit for the carry out
  logic [`IMULDIV_XLEN:0]   rem_sh;
  // trial subtraction, top bit set means it went negative
  logic [`IMULDIV_XLEN:0]   diff;
  logic                     fits;

  // --------------------------------------------------
  // trial subtract
  // --------------------------------------------------

  // shift the {rem, quot} pair left by one, next dividend bit enters rem
  assign rem_sh = {rem, quot[msb]};
  assign diff   = rem_sh - {1'b0, divisor};
  assign fits   = ~diff[`IMULDIV_XLEN];

  // --------------------------------------------------
  // iteration
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rem     <= '0;
      quot    <= '0;
      divisor <= '0;
    end else if (ctrl.load) begin
      // dividend is shifted out of the quotient register bit by bit
      rem     <= '0;
      quot    <= mag_a;
      divisor <= mag_b;
    end else if (ctrl.step) begin
      if (fits) begin
        // keep the difference and record a one
        rem  <= diff[msb:0];
        quot <= {quot[msb-1:0], 1'b1};
      end else begin
        // restore, i.e. keep the shifted value
        rem  <= rem_sh[msb:0];
        quot <= {quot[msb-1:0], 1'b0};
      end
    end
  end

  // zero divisor always fits, which leaves all ones and the dividend
  assign quot_mag = quot;
  assign rem_mag  = rem;

endmodule

/* src/imuldiv_iterative.sv */
// --------------------------------------------------
// imuldiv iterative top
// 32-step signed mul and signed/unsigned divide
// --------------------------------------------------

`timescale 1ns/1ns

`include "imuldiv_defs.svh"

module imuldiv_iterative import imuldiv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,

  // request
  input  imuldiv_req_t               req,
  input  logic                       req_val,
  output logic                       req_rdy,

  // response
  output logic [2*`IMULDIV_XLEN-1:0] resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  imuldiv_ctrl_t              ctrl;

  // magnitudes shared by both arithmetic blocks
  logic [`IMULDIV_XLEN-1:0]   mag_a;
  logic [`IMULDIV_XLEN-1:0]   mag_b;

  // unsigned results
  logic [2*`IMULDIV_XLEN-1:0] product_mag;
  logic [`IMULDIV_XLEN-1:0]   quot_mag;
  logic [`IMULDIV_XLEN-1:0]   rem_mag;

  // --------------------------------------------------
  // control and datapath blocks
  // --------------------------------------------------

  // handshakes and the load/step word
  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl)
  );

  // sign handling around the unsigned cores
  imuldiv_sign_unit u_sign (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .ctrl        (ctrl),
    .product_mag (product_mag),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .mag_a       (mag_a),
    .mag_b       (mag_b),
    .resp_result (resp_result)
  );

  // both cores run every request, the sign unit picks one
  imuldiv_mul_dpath u_mul (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .mag_a       (mag_a),
    .mag_b       (mag_b),
    .product_mag (product_mag)
  );

  imuldiv_div_dpath u_div (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

endmodule

/* dv/imuldiv_tb.sv */
// --------------------------------------------------
// imuldiv testbench
// random and corner requests checked against a model
// --------------------------------------------------

`timescale 1ns/1ns

`include "imuldiv_defs.svh"

module imuldiv_tb import imuldiv_pkg::*; ();

  // response rises this many edges after the accepting edge
  localparam int latency    = `IMULDIV_STEPS;
  localparam int wait_limit = 200;

  logic                       clk;
  logic                       reset;
  imuldiv_req_t               req;
  logic                       req_val;
  logic                       req_rdy;
  logic [2*`IMULDIV_XLEN-1:0] resp_result;
  logic                       resp_val;
  logic                       resp_rdy;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr;

  // multiply corners with zero, minus one and the most negative value
  logic [31:0] corner_a [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                32'h8000_0000, 32'h7fff_ffff, 32'h1234_5678};
  logic [31:0] corner_b [6] = '{32'h8765_4321, 32'hffff_ffff, 32'h8000_0000,
                                32'hffff_ffff, 32'h8000_0000, 32'h0};

  always #50 clk = ~clk;

  imuldiv_iterative DUT (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // --------------------------------------------------
  // handshake properties
  // --------------------------------------------------

  // a stalled response holds everything
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && !req_rdy && $stable(resp_result)))
    else begin
      $display("response changed or dropped while resp_rdy was low");
      errors++;
    end

  // --------------------------------------------------
  // random numbers and reference model
  // --------------------------------------------------

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic imuldiv_op_e random_op();
    logic [31:0] r;
    r = rand_bits(2);
    case (r)
      32'd0:   return op_mul;
      32'd1:   return op_div;
      default: return op_divu;
    endcase
  endfunction

  // divides give {remainder, quotient}
  function automatic logic [63:0] model_result(input imuldiv_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (op == op_mul) begin
      return sa * sb;
    end
    // a zero divisor gives an all ones quotient and the dividend back
    if (b == 32'h0) begin
      return {a, 32'hffff_ffff};
    end
    if (op == op_divu) begin
      return {a % b, a / b};
    end
    // quotient truncates toward zero and the remainder follows the dividend
    q = sa / sb;
    r = sa % sb;
    return {r[31:0], q[31:0]};
  endfunction

  // --------------------------------------------------
  // checks and one request/response transaction
  // --------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // called and returns 1 ns after a rising edge
  task automatic run_op(input imuldiv_op_e op, input logic [31:0] a,
                        input logic [31:0] b, input int hold);
    int          n;
    logic [63:0] exp;
    logic [63:0] held;
    exp      = model_result(op, a, b);
    resp_rdy = (hold == 0);
    n = 0;
    while (!req_rdy && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!req_rdy) begin
      $display("timed out waiting for req_rdy");
      errors++;
      return;
    end
    req.op  = op;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    @(posedge clk);
    #1;
    // junk on the bus once accepted
    req_val = 1'b0;
    req.op  = (op == op_mul) ? op_div : op_mul;
    req.a   = rand_bits(32);
    req.b   = rand_bits(32);
    n = 0;
    while (!resp_val && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!resp_val) begin
      $display("timed out waiting for resp_val");
      errors++;
      return;
    end
    assert (n == latency) else begin
      $display("mismatch latency: got %h expected %h", n, latency);
      errors++;
    end
    check_value("resp_result", resp_result, exp);
    held = resp_result;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #1;
      check_bit("resp_val", resp_val, 1'b1);
      check_bit("req_rdy", req_rdy, 1'b0);
      check_value("resp_result", resp_result, held);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
    check_bit("resp_val", resp_val, 1'b0);
    check_bit("req_rdy", req_rdy, 1'b1);
  endtask

  task automatic end_test(input string name, input int errors_at_start);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    int          mark;
    logic [31:0] a;
    logic [31:0] b;
    clk          = 1'b0;
    reset        = 1'b1;
    req          = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr         = 32'hdc54_6215;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    mark = errors;
    for (int i = 0; i < 3; i++) begin
      check_bit("req_rdy", req_rdy, 1'b1);
      check_bit("resp_val", resp_val, 1'b0);
      @(posedge clk);
      #1;
    end
    end_test("reset", mark);

    mark = errors;
    for (int i = 0; i < 6; i++) begin
      run_op(op_mul, corner_a[i], corner_b[i], 0);
    end
    for (int i = 0; i < 16; i++) begin
      run_op(op_mul, rand_bits(32), rand_bits(32), 0);
    end
    end_test("signed multiply", mark);

    mark = errors;
    for (int i = 0; i < 16; i++) begin
      a = rand_bits(32);
      b = rand_bits(32) >> rand_bits(5);
      run_op(op_divu, a, b | 32'h1, 0);
    end
    end_test("unsigned divide", mark);

    mark = errors;
    run_op(op_div, 32'd7, 32'd2, 0);
    run_op(op_div, -32'sd7, 32'd2, 0);
    run_op(op_div, 32'd7, -32'sd2, 0);
    run_op(op_div, -32'sd7, -32'sd2, 0);
    run_op(op_div, 32'h8000_0000, 32'hffff_ffff, 0);
    for (int i = 0; i < 16; i++) begin
      a     = rand_bits(32);
      a[31] = i[0];
      b     = rand_bits(16) + 1;
      b     = i[1] ? -b : b;
      run_op(op_div, a, b, 0);
    end
    end_test("signed divide", mark);

    mark = errors;
    run_op(op_div, 32'd100, 32'h0, 0);
    run_op(op_div, 32'hffff_ff9c, 32'h0, 0);
    run_op(op_divu, 32'hffff_ff9c, 32'h0, 0);
    run_op(op_divu, rand_bits(32), 32'h0, 0);
    end_test("divide by zero", mark);

    mark = errors;
    for (int i = 0; i < 6; i++) begin
      run_op(random_op(), rand_bits(32), rand_bits(32), rand_bits(3) + 1);
    end
    end_test("back-pressure", mark);

    // resp_rdy stays high so each request follows the last transfer
    mark = errors;
    for (int i = 0; i < 8; i++) begin
      run_op(random_op(), rand_bits(32), rand_bits(32), 0);
    end
    end_test("back-to-back", mark);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* imuldiv.f */
+incdir+src
src/imuldiv_pkg.sv
src/imuldiv_ctrl.sv
src/imuldiv_sign_unit.sv
src/imuldiv_mul_dpath.sv
src/imuldiv_div_dpath.sv
src/imuldiv_iterative.sv
dv/imuldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the imuldiv testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f imuldiv.f \
  --top-module imuldiv_tb

./obj_dir/Vimuldiv_tb | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
